// ==== Makefile ====
# Verilator build and run for the trellis tracker testbench

VERILATOR ?= verilator
TOP       ?= tbCpmTrellis
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard verilog/*.sv verification/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/trellis_config.svh ====
`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// state metric width, all metric arithmetic wraps at this size
`define ACS_BITS 8

// rotated sample width, unity gain sits at 2^(ROT_BITS-2)
`define ROT_BITS 8

// matched filter width, only the top ROT_BITS bits reach the rotator
`define MF_BITS 10

// 32 angle steps around the circle
`define ANGLE_BITS 5

// trellis states, which is also the number of branches into each state
`define NUM_STATES 4

// the four branch slots need this many clocks between symbol strobes
`define SYMBOL_CLOCKS 4

`endif

// ==== list.f ====
+incdir+include
verilog/trellisPkg.sv
verilog/branchSequencer.sv
verilog/phaseRotator.sv
verilog/acsNode.sv
verilog/metricBank.sv
verilog/cpmTrellisTop.sv
verification/trellisChecker.sv
verification/tbCpmTrellis.sv

// ==== verification/tbCpmTrellis.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module tbCpmTrellis;

   localparam int numSymbols   = 400;
   localparam int maxGap       = 7;
   localparam int timeoutLimit = numSymbols * maxGap + 100;

   logic                        clk;
   logic                        reset;
   logic                        symEn;
   trellisPkg::sampleT          sample;
   logic [`ANGLE_BITS-1:0]      tiltStep;
   logic                        outValid;
   logic [1:0]                  bestState;
   logic [`ACS_BITS-1:0]        bestMetric;
   trellisPkg::rotSampleT       bestSample;
   logic [`NUM_STATES-1:0][1:0] decisions;
   logic                        normalized;
   int                          errorCount;
   int                          resultCount;
   int                          symbolCount;
   int                          pendingCount;
   integer                      seed;
   int                          cycleCount = 0;

   cpmTrellisTop i_cpmTrellisTop (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sample     (sample),
      .tiltStep   (tiltStep),
      .outValid   (outValid),
      .bestState  (bestState),
      .bestMetric (bestMetric),
      .bestSample (bestSample),
      .decisions  (decisions),
      .normalized (normalized)
   );

   trellisChecker i_trellisChecker (
      .clk          (clk),
      .reset        (reset),
      .symEn        (symEn),
      .sample       (sample),
      .tiltStep     (tiltStep),
      .outValid     (outValid),
      .bestState    (bestState),
      .bestMetric   (bestMetric),
      .bestSample   (bestSample),
      .decisions    (decisions),
      .normalized   (normalized),
      .errorCount   (errorCount),
      .resultCount  (resultCount),
      .symbolCount  (symbolCount),
      .pendingCount (pendingCount)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= timeoutLimit) begin
         $display("timeout after %0d cycles with %0d results pending", cycleCount, pendingCount);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      logic [31:0] gapWord;
      logic [31:0] dataWord;
      logic [31:0] tiltWord;
      int          gap;
      seed     = 32'h4fbe;
      reset    = 1'b1;
      symEn    = 1'b0;
      sample   = '0;
      tiltStep = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);
      for (int s = 0; s < numSymbols; s++) begin
         gapWord  = $random(seed);
         dataWord = $random(seed);
         tiltWord = $random(seed);
         // every tenth strobe comes at the minimum spacing, two symbols in flight
         gap = (s % 10 == 0) ? `SYMBOL_CLOCKS : `SYMBOL_CLOCKS + int'(gapWord[1:0]);
         if (s >= 200 && s < 260) begin
            // strong positive I keeps the winning metrics climbing
            sample.i = 10'sd384 + 10'(dataWord[8:2]);
            sample.q = {{4{dataWord[14]}}, dataWord[14:9]};
         end else begin
            sample.i = dataWord[9:0];
            sample.q = dataWord[25:16];
         end
         tiltStep = (s < 100) ? '0 : tiltWord[`ANGLE_BITS-1:0];
         symEn    = 1'b1;
         @(negedge clk);
         symEn = 1'b0;
         repeat (gap - 1) @(negedge clk);
      end
      while (pendingCount != 0) @(posedge clk);
      repeat (12) @(posedge clk);
      $display("symbols=%0d results=%0d errors=%0d", symbolCount, resultCount, errorCount);
      if (errorCount == 0 && resultCount == numSymbols) begin
         $display("Simulation PASSED");
      end else begin
         if (resultCount != numSymbols) begin
            $display("expected %0d results but the checker saw %0d", numSymbols, resultCount);
         end
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/trellisChecker.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module trellisChecker (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        symEn,
   input  trellisPkg::sampleT          sample,
   input  logic [`ANGLE_BITS-1:0]      tiltStep,
   input  logic                        outValid,
   input  logic [1:0]                  bestState,
   input  logic [`ACS_BITS-1:0]        bestMetric,
   input  trellisPkg::rotSampleT       bestSample,
   input  logic [`NUM_STATES-1:0][1:0] decisions,
   input  logic                        normalized,
   output int                          errorCount,
   output int                          resultCount,
   output int                          symbolCount,
   output int                          pendingCount
);

   localparam int  angleSteps = 2**`ANGLE_BITS;
   localparam real twoPi      = 6.283185307179586;

   typedef struct packed {
      logic [31:0]                 due;
      logic [1:0]                  bestState;
      logic [`ACS_BITS-1:0]        bestMetric;
      trellisPkg::rotSampleT       bestSample;
      logic [`NUM_STATES-1:0][1:0] decisions;
      logic                        normalized;
   } expectT;

   expectT                 expectQ [$];
   int                     cosRef [angleSteps];
   int                     sinRef [angleSteps];
   logic [`ACS_BITS-1:0]   modelMetrics [`NUM_STATES];
   trellisPkg::hIndexE     modelIndex;
   logic [`ANGLE_BITS-1:0] modelTilt;
   int                     cycleCount;
   logic                   seenOutput;
   logic                   resetSeen;
   logic                   symSeen;
   trellisPkg::sampleT     sampleSeen;
   logic [`ANGLE_BITS-1:0] stepSeen;

   // reference sine and cosine at a gain of 63, rounded to nearest
   initial begin
      real angleRad;
      for (int k = 0; k < angleSteps; k++) begin
         angleRad  = twoPi * k / angleSteps;
         cosRef[k] = $rtoi($floor(63.0 * $cos(angleRad) + 0.5));
         sinRef[k] = $rtoi($floor(63.0 * $sin(angleRad) + 0.5));
      end
   end

   function automatic trellisPkg::rotSampleT rotateRef(
      input logic signed [`ROT_BITS-1:0] i,
      input logic signed [`ROT_BITS-1:0] q,
      input int                          angle
   );
      int                    shiftI;
      int                    shiftQ;
      trellisPkg::rotSampleT result;
      shiftI   = (int'(i) * cosRef[angle] - int'(q) * sinRef[angle]) >>> (`ROT_BITS - 2);
      shiftQ   = (int'(i) * sinRef[angle] + int'(q) * cosRef[angle]) >>> (`ROT_BITS - 2);
      result.i = shiftI[`ROT_BITS-1:0];
      result.q = shiftQ[`ROT_BITS-1:0];
      return result;
   endfunction

   // one whole symbol through the trellis, in strobe order
   task automatic runSymbol(input trellisPkg::sampleT smp, input logic [`ANGLE_BITS-1:0] step);
      logic signed [`ROT_BITS-1:0] topI;
      logic signed [`ROT_BITS-1:0] topQ;
      int                          angle;
      int                          best;
      trellisPkg::rotSampleT       rot;
      trellisPkg::rotSampleT       winSample [`NUM_STATES];
      logic signed [`ACS_BITS-1:0] sum;
      logic signed [`ACS_BITS-1:0] winMetric [`NUM_STATES];
      logic [`ACS_BITS-1:0]        newMetrics [`NUM_STATES];
      logic                        anyNorm;
      expectT                      expected;
      // the index flips first, and the tilt steps when the new symbol is 5/4
      if (modelIndex == trellisPkg::H45) begin
         modelIndex = trellisPkg::H54;
         modelTilt  = modelTilt + step;
      end else begin
         modelIndex = trellisPkg::H45;
      end
      topI    = smp.i[`MF_BITS-1 -: `ROT_BITS];
      topQ    = smp.q[`MF_BITS-1 -: `ROT_BITS];
      anyNorm = 1'b0;
      for (int n = 0; n < `NUM_STATES; n++) begin
         for (int k = 0; k < `NUM_STATES; k++) begin
            angle = 2 * int'(trellisPkg::branchPhaseTable[modelIndex][n][k]);
            angle = (angleSteps - ((int'(modelTilt) + angle) % angleSteps)) % angleSteps;
            rot   = rotateRef(topI, topQ, angle);
            sum   = rot.i + modelMetrics[n ^ k];
            if (k == 0 || sum > winMetric[n]) begin
               winMetric[n]          = sum;
               winSample[n]          = rot;
               expected.decisions[n] = 2'(k);
            end
         end
         if (winMetric[n][`ACS_BITS-1 -: 2] == 2'b01) begin
            anyNorm = 1'b1;
         end
      end
      for (int n = 0; n < `NUM_STATES; n++) begin
         newMetrics[n] = anyNorm ? winMetric[n] - (1 << (`ACS_BITS - 2)) : winMetric[n];
         modelMetrics[n] = newMetrics[n];
      end
      best = 0;
      for (int n = 1; n < `NUM_STATES; n++) begin
         if ($signed(newMetrics[n]) > $signed(newMetrics[best])) begin
            best = n;
         end
      end
      // the strobe sat in the cycle before this one, so the result is 8 after it
      expected.due        = cycleCount + 7;
      expected.bestState  = 2'(best);
      expected.bestMetric = newMetrics[best];
      expected.bestSample = winSample[best];
      expected.normalized = anyNorm;
      expectQ.push_back(expected);
   endtask

   task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("MISMATCH %s expected %h got %h at cycle %0d", name, want, got, cycleCount);
         errorCount++;
      end
   endtask

   always @(posedge clk) begin
      resetSeen  <= reset;
      symSeen    <= symEn;
      sampleSeen <= sample;
      stepSeen   <= tiltStep;
   end

   // outputs settle after the rising edge, so they are compared on the falling one
   always @(negedge clk) begin
      expectT expected;
      if (resetSeen) begin
         cycleCount  = 0;
         errorCount  = 0;
         resultCount = 0;
         symbolCount = 0;
         seenOutput  = 1'b0;
         modelIndex  = trellisPkg::H45;
         modelTilt   = '0;
         for (int n = 0; n < `NUM_STATES; n++) begin
            modelMetrics[n] = '0;
         end
         expectQ.delete();
      end else begin
         cycleCount++;
         if (expectQ.size() > 0 && expectQ[0].due == cycleCount) begin
            expected = expectQ.pop_front();
            if (outValid !== 1'b1) begin
               $display("outValid missing at cycle %0d", cycleCount);
               errorCount++;
            end else begin
               seenOutput = 1'b1;
               resultCount++;
               checkField("bestState", 32'(bestState), 32'(expected.bestState));
               checkField("bestMetric", 32'(bestMetric), 32'(expected.bestMetric));
               checkField("bestSample", 32'(bestSample), 32'(expected.bestSample));
               checkField("decisions", 32'(decisions), 32'(expected.decisions));
               checkField("normalized", 32'(normalized), 32'(expected.normalized));
            end
         end else if (outValid !== 1'b0) begin
            $display("outValid high at cycle %0d with no result due", cycleCount);
            errorCount++;
         end
         if (!seenOutput && normalized !== 1'b0) begin
            $display("normalized high before the first result at cycle %0d", cycleCount);
            errorCount++;
         end
         if (symSeen) begin
            runSymbol(sampleSeen, stepSeen);
            symbolCount++;
         end
      end
      pendingCount = expectQ.size();
   end

endmodule

// ==== verilog/acsNode.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module acsNode #(
   parameter int NODE_INDEX = 0
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  trellisPkg::branchCtrlT                branchCtrl,
   input  logic [`NUM_STATES-1:0][`ACS_BITS-1:0] stateMetrics,
   output trellisPkg::nodeOutT                   nodeOut,
   output logic                                  nodeValid
);

   logic [`ANGLE_BITS-2:0]      branchPhase;
   logic [`ANGLE_BITS-1:0]      phaseSum;
   logic [`ANGLE_BITS-1:0]      rotAngle;
   trellisPkg::rotSampleT       rotIn;
   trellisPkg::rotSampleT       rotOut;
   logic                        slotActive;
   logic                        lastSlotIn;
   logic                        lastSlotOut;
   logic [1:0]                  slotDelay1;
   logic [1:0]                  slotDelay2;
   trellisPkg::rotSampleT       capturedSlots [`NUM_STATES-1];
   trellisPkg::rotSampleT       slotSamples [`NUM_STATES];
   logic signed [`ACS_BITS-1:0] sums [`NUM_STATES];
   logic signed [`ACS_BITS-1:0] bestSum;
   logic [1:0]                  bestSel;

   // angle is 32 minus (tilt + 2 * phase), which in five bits is just the negated sum
   always_comb begin
      branchPhase = trellisPkg::branchPhaseTable[branchCtrl.hIndex][NODE_INDEX][branchCtrl.slot];
      phaseSum    = branchCtrl.tilt + {branchPhase, 1'b0};
      rotAngle    = -phaseSum;
      rotIn.i     = branchCtrl.sample.i[`MF_BITS-1 -: `ROT_BITS];
      rotIn.q     = branchCtrl.sample.q[`MF_BITS-1 -: `ROT_BITS];
   end

   // slot 3 also shows while idle, so only the one that follows a first slot counts
   assign lastSlotIn = (branchCtrl.slot == 2'd3) && slotActive;

   always_ff @(posedge clk) begin
      if (reset) begin
         slotActive <= 1'b0;
         slotDelay1 <= 2'd3;
         slotDelay2 <= 2'd3;
      end else begin
         if (branchCtrl.firstSlot) begin
            slotActive <= 1'b1;
         end else if (lastSlotIn) begin
            slotActive <= 1'b0;
         end
         slotDelay1 <= branchCtrl.slot;
         slotDelay2 <= slotDelay1;
      end
   end

   // the strobe marks the last slot, so it leaves the rotator together with that slot
   phaseRotator i_phaseRotator (
      .clk       (clk),
      .reset     (reset),
      .inSample  (rotIn),
      .angle     (rotAngle),
      .inStrobe  (lastSlotIn),
      .outSample (rotOut),
      .outStrobe (lastSlotOut)
   );

   // serial to parallel, slots 0 to 2 are kept and slot 3 is used straight off the rotator
   always_ff @(posedge clk) begin
      if (slotDelay2 != 2'd3) begin
         capturedSlots[slotDelay2] <= rotOut;
      end
   end

   always_comb begin
      for (int k = 0; k < `NUM_STATES - 1; k++) begin
         slotSamples[k] = capturedSlots[k];
      end
      slotSamples[`NUM_STATES-1] = rotOut;
   end

   // the metric sums wrap, and the strict compare leaves ties with the lower branch
   always_comb begin
      logic signed [`ACS_BITS-1:0] extI;
      for (int k = 0; k < `NUM_STATES; k++) begin
         extI    = slotSamples[k].i;
         sums[k] = extI + stateMetrics[trellisPkg::predecessorTable[NODE_INDEX][k]];
      end
      bestSum = sums[0];
      bestSel = 2'd0;
      for (int k = 1; k < `NUM_STATES; k++) begin
         if (sums[k] > bestSum) begin
            bestSum = sums[k];
            bestSel = 2'(k);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lastSlotOut) begin
         nodeOut.metric    <= bestSum;
         nodeOut.sel       <= bestSel;
         nodeOut.rotSample <= slotSamples[bestSel];
         // 01 on top means the metric is one more climb away from wrapping negative
         nodeOut.normFlag  <= (bestSum[`ACS_BITS-1 -: 2] == 2'b01);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         nodeValid <= 1'b0;
      end else begin
         nodeValid <= lastSlotOut;
      end
   end

   // one result per symbol, even when strobes come as close as the sequencer allows
   singleValidCheck: assert property (@(posedge clk) disable iff (reset)
      nodeValid |=> !nodeValid);

endmodule

// ==== verilog/branchSequencer.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module branchSequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   symEn,
   input  trellisPkg::sampleT     sample,
   input  logic [`ANGLE_BITS-1:0] tiltStep,
   output trellisPkg::branchCtrlT branchCtrl
);

   localparam int symbolGap = `SYMBOL_CLOCKS - 1;

   logic [1:0]             slot;
   logic                   firstSlot;
   trellisPkg::hIndexE     hIndex;
   logic [`ANGLE_BITS-1:0] tilt;
   trellisPkg::sampleT     heldSample;

   // the slot count parks at 3 between symbols, so idle cycles look like the last slot
   always_ff @(posedge clk) begin
      if (reset) begin
         slot      <= 2'd3;
         firstSlot <= 1'b0;
         hIndex    <= trellisPkg::H45;
         tilt      <= '0;
      end else if (symEn) begin
         slot      <= 2'd0;
         firstSlot <= 1'b1;
         if (hIndex == trellisPkg::H45) begin
            // this symbol runs at 5/4, which is where the tilt steps forward
            hIndex <= trellisPkg::H54;
            tilt   <= tilt + tiltStep;
         end else begin
            hIndex <= trellisPkg::H45;
         end
      end else begin
         firstSlot <= 1'b0;
         if (slot != 2'd3) begin
            slot <= slot + 2'd1;
         end
      end
   end

   // the sample stays put for all four branch slots
   always_ff @(posedge clk) begin
      if (symEn) begin
         heldSample <= sample;
      end
   end

   always_comb begin
      branchCtrl.slot      = slot;
      branchCtrl.firstSlot = firstSlot;
      branchCtrl.hIndex    = hIndex;
      branchCtrl.tilt      = tilt;
      branchCtrl.sample    = heldSample;
   end

   // a strobe inside the slot window would cut the previous symbol short in every node
   symbolGapCheck: assert property (@(posedge clk) disable iff (reset)
      symEn |=> !symEn [*symbolGap]);

endmodule

// ==== verilog/cpmTrellisTop.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module cpmTrellisTop (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        symEn,
   input  trellisPkg::sampleT          sample,
   input  logic [`ANGLE_BITS-1:0]      tiltStep,
   output logic                        outValid,
   output logic [1:0]                  bestState,
   output logic [`ACS_BITS-1:0]        bestMetric,
   output trellisPkg::rotSampleT       bestSample,
   output logic [`NUM_STATES-1:0][1:0] decisions,
   output logic                        normalized
);

   trellisPkg::branchCtrlT                branchCtrl;
   logic [`NUM_STATES-1:0][`ACS_BITS-1:0] stateMetrics;
   trellisPkg::nodeOutT [`NUM_STATES-1:0] nodeOuts;
   logic [`NUM_STATES-1:0]                nodeValids;

   branchSequencer i_branchSequencer (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sample     (sample),
      .tiltStep   (tiltStep),
      .branchCtrl (branchCtrl)
   );

   for (genvar n = 0; n < `NUM_STATES; n++) begin : nodeGen
      acsNode #(
         .NODE_INDEX (n)
      ) i_acsNode (
         .clk          (clk),
         .reset        (reset),
         .branchCtrl   (branchCtrl),
         .stateMetrics (stateMetrics),
         .nodeOut      (nodeOuts[n]),
         .nodeValid    (nodeValids[n])
      );
   end

   // all nodes see the same control word, so node 0 speaks for the rest
   metricBank i_metricBank (
      .clk          (clk),
      .reset        (reset),
      .nodeOuts     (nodeOuts),
      .nodeValid    (nodeValids[0]),
      .stateMetrics (stateMetrics),
      .outValid     (outValid),
      .bestState    (bestState),
      .bestMetric   (bestMetric),
      .bestSample   (bestSample),
      .decisions    (decisions),
      .normalized   (normalized)
   );

endmodule

// ==== verilog/metricBank.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module metricBank (
   input  logic                                  clk,
   input  logic                                  reset,
   input  trellisPkg::nodeOutT [`NUM_STATES-1:0] nodeOuts,
   input  logic                                  nodeValid,
   output logic [`NUM_STATES-1:0][`ACS_BITS-1:0] stateMetrics,
   output logic                                  outValid,
   output logic [1:0]                            bestState,
   output logic [`ACS_BITS-1:0]                  bestMetric,
   output trellisPkg::rotSampleT                 bestSample,
   output logic [`NUM_STATES-1:0][1:0]           decisions,
   output logic                                  normalized
);

   localparam logic [`ACS_BITS-1:0] normStep = 1 << (`ACS_BITS - 2);

   logic                                  anyNorm;
   logic [`NUM_STATES-1:0][`ACS_BITS-1:0] newMetrics;
   logic [1:0]                            bestIndex;

   // one flag from any node pulls every metric down by the same amount
   always_comb begin
      anyNorm = 1'b0;
      for (int n = 0; n < `NUM_STATES; n++) begin
         anyNorm = anyNorm | nodeOuts[n].normFlag;
      end
      for (int n = 0; n < `NUM_STATES; n++) begin
         if (anyNorm) begin
            newMetrics[n] = nodeOuts[n].metric - normStep;
         end else begin
            newMetrics[n] = nodeOuts[n].metric;
         end
      end
   end

   // best state is picked on the metrics as they will be stored
   always_comb begin
      bestIndex = 2'd0;
      for (int n = 1; n < `NUM_STATES; n++) begin
         if ($signed(newMetrics[n]) > $signed(newMetrics[bestIndex])) begin
            bestIndex = 2'(n);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stateMetrics <= '0;
         outValid     <= 1'b0;
         normalized   <= 1'b0;
      end else begin
         outValid <= nodeValid;
         if (nodeValid) begin
            stateMetrics <= newMetrics;
            normalized   <= anyNorm;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nodeValid) begin
         bestState  <= bestIndex;
         bestMetric <= newMetrics[bestIndex];
         bestSample <= nodeOuts[bestIndex].rotSample;
         for (int n = 0; n < `NUM_STATES; n++) begin
            decisions[n] <= nodeOuts[n].sel;
         end
      end
   end

endmodule

// ==== verilog/phaseRotator.sv ====
`timescale 1ns/1ps
`include "trellis_config.svh"

module phaseRotator (
   input  logic                   clk,
   input  logic                   reset,
   input  trellisPkg::rotSampleT  inSample,
   input  logic [`ANGLE_BITS-1:0] angle,
   input  logic                   inStrobe,
   output trellisPkg::rotSampleT  outSample,
   output logic                   outStrobe
);

   localparam int fracBits = `ROT_BITS - 2;

   logic signed [`ROT_BITS-1:0]   cosVal;
   logic signed [`ROT_BITS-1:0]   sinVal;
   logic signed [2*`ROT_BITS-1:0] prodIc;
   logic signed [2*`ROT_BITS-1:0] prodQs;
   logic signed [2*`ROT_BITS-1:0] prodIs;
   logic signed [2*`ROT_BITS-1:0] prodQc;
   logic signed [2*`ROT_BITS:0]   sumI;
   logic signed [2*`ROT_BITS:0]   sumQ;
   logic signed [2*`ROT_BITS:0]   scaledI;
   logic signed [2*`ROT_BITS:0]   scaledQ;
   logic                          midStrobe;

   always_comb begin
      cosVal = trellisPkg::cosTable[angle];
      sinVal = trellisPkg::sinTable[angle];
   end

   // stage one holds the four partial products
   always_ff @(posedge clk) begin
      prodIc <= inSample.i * cosVal;
      prodQs <= inSample.q * sinVal;
      prodIs <= inSample.i * sinVal;
      prodQc <= inSample.q * cosVal;
   end

   // the table gain is 63, close enough to 64 that a plain shift brings it back to scale
   always_comb begin
      sumI    = prodIc - prodQs;
      sumQ    = prodIs + prodQc;
      scaledI = sumI >>> fracBits;
      scaledQ = sumQ >>> fracBits;
   end

   // stage two truncates back to the sample width
   always_ff @(posedge clk) begin
      outSample.i <= scaledI[`ROT_BITS-1:0];
      outSample.q <= scaledQ[`ROT_BITS-1:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         midStrobe <= 1'b0;
         outStrobe <= 1'b0;
      end else begin
         midStrobe <= inStrobe;
         outStrobe <= midStrobe;
      end
   end

endmodule

// ==== verilog/trellisPkg.sv ====
`include "trellis_config.svh"

package trellisPkg;

   typedef struct packed {
      logic signed [`MF_BITS-1:0] i;
      logic signed [`MF_BITS-1:0] q;
   } sampleT;

   typedef struct packed {
      logic signed [`ROT_BITS-1:0] i;
      logic signed [`ROT_BITS-1:0] q;
   } rotSampleT;

   // modulation index of the current symbol, 4/5 and 5/4 alternate
   typedef enum logic {
      H45 = 1'b0,
      H54 = 1'b1
   } hIndexE;

   typedef struct packed {
      logic [1:0]             slot;
      logic                   firstSlot;
      hIndexE                 hIndex;
      logic [`ANGLE_BITS-1:0] tilt;
      sampleT                 sample;
   } branchCtrlT;

   typedef struct packed {
      logic signed [`ACS_BITS-1:0] metric;
      logic [1:0]                  sel;
      rotSampleT                   rotSample;
      logic                        normFlag;
   } nodeOutT;

   // round(63 * cos(2*pi*k/32)) and the matching sine
   localparam logic signed [`ROT_BITS-1:0] cosTable [2**`ANGLE_BITS] = '{
      63, 62, 58, 52, 45, 35, 24, 12, 0, -12, -24, -35, -45, -52, -58, -62,
      -63, -62, -58, -52, -45, -35, -24, -12, 0, 12, 24, 35, 45, 52, 58, 62
   };

   localparam logic signed [`ROT_BITS-1:0] sinTable [2**`ANGLE_BITS] = '{
      0, 12, 24, 35, 45, 52, 58, 62, 63, 62, 58, 52, 45, 35, 24, 12,
      0, -12, -24, -35, -45, -52, -58, -62, -63, -62, -58, -52, -45, -35, -24, -12
   };

   // branch phases in angle steps, first index is H45 then H54, then node, then slot
   localparam logic [`ANGLE_BITS-2:0] branchPhaseTable [2][`NUM_STATES][`NUM_STATES] = '{
      '{'{0, 4, 8, 12}, '{2, 6, 10, 14}, '{8, 12, 0, 4}, '{10, 14, 2, 6}},
      '{'{0, 5, 10, 15}, '{3, 8, 13, 2}, '{10, 15, 4, 9}, '{13, 2, 7, 12}}
   };

   // branch k into node n leaves from state n xor k
   localparam logic [1:0] predecessorTable [`NUM_STATES][`NUM_STATES] = '{
      '{0, 1, 2, 3},
      '{1, 0, 3, 2},
      '{2, 3, 0, 1},
      '{3, 2, 1, 0}
   };

endpackage
